// File: hw/accel_params.svh
`ifndef ACCEL_PARAMS_SVH
`define ACCEL_PARAMS_SVH

// Pad and buffer word
`define PORT_WIDTH      32
`define ACT_WIDTH       8
`define NUM_LANE        4

// Global buffer geometry
`define GLB_DEPTH       64
`define GLB_ADDR_WIDTH  6
`define OUT_BASE        32
`define MAX_IN_WORDS    32

// Pooling group size in words
`define POOL_K          4

// Start button filter length
`define DEB_CYCLES      16

`define CNT_WIDTH       6

`endif

// File: hw/accelPkg.sv
`include "accel_params.svh"

package accelPkg;

    // One buffer or pad word, four activation lanes
    typedef logic [`PORT_WIDTH-1:0]     wordT;
    typedef logic [`ACT_WIDTH-1:0]      actT;

    typedef logic [`GLB_ADDR_WIDTH-1:0] glbAddrT;
    typedef logic [`CNT_WIDTH-1:0]      cntT;

    // Top-level run phases
    typedef enum logic [1:0] {
        ST_LOAD,
        ST_POOL,
        ST_DUMP,
        ST_DONE
    } ctrlStateT;

endpackage

// File: hw/glbRdIf.sv
`timescale 1ns/1ps

interface glbRdIf
    import accelPkg::*;
();
    logic    rdEn;
    glbAddrT rdAddr;
    wordT    rdDat;
    logic    rdVld;

    // rdVld follows rdEn by one cycle
    modport client (
        output rdEn,
        output rdAddr,
        input  rdDat,
        input  rdVld
    );

    modport buffer (
        input  rdEn,
        input  rdAddr,
        output rdDat,
        output rdVld
    );

endinterface

// File: hw/startDebounce.sv
`timescale 1ns/1ps
`include "accel_params.svh"

module startDebounce (
    input  logic clk,
    input  logic rstN,
    input  logic btn,
    output logic start
);
    localparam int DebW = $clog2(`DEB_CYCLES);

    logic [DebW-1:0] debCnt;
    logic            btnLvl;
    logic            btnLvlD;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            debCnt  <= '0;
            btnLvl  <= 1'b0;
            btnLvlD <= 1'b0;
            start   <= 1'b0;
        end else begin
            btnLvlD <= btnLvl;
            // Strobe one cycle after the accepted level drops
            start   <= btnLvlD && !btnLvl;
            if (btn == btnLvl) begin
                debCnt <= '0;
            end else if (debCnt == DebW'(`DEB_CYCLES - 1)) begin
                debCnt <= '0;
                btnLvl <= btn;
            end else begin
                debCnt <= debCnt + 1'b1;
            end
        end
    end

endmodule

// File: hw/globalBuffer.sv
`timescale 1ns/1ps
`include "accel_params.svh"

module globalBuffer
    import accelPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  logic    itfWrEn,
    input  glbAddrT itfWrAddr,
    input  wordT    itfWrDat,
    input  logic    polWrEn,
    input  glbAddrT polWrAddr,
    input  wordT    polWrDat,
    glbRdIf.buffer  itfRd,
    glbRdIf.buffer  polRd
);
    wordT    mem [`GLB_DEPTH];
    glbAddrT rdAddr;
    wordT    rdDatQ;

    // Pooling side always wins
    assign rdAddr = polRd.rdEn ? polRd.rdAddr : itfRd.rdAddr;

    always_ff @(posedge clk) begin
        if (polWrEn) begin
            mem[polWrAddr] <= polWrDat;
        end else if (itfWrEn) begin
            mem[itfWrAddr] <= itfWrDat;
        end
        if (polRd.rdEn || itfRd.rdEn) begin
            rdDatQ <= mem[rdAddr];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            polRd.rdVld <= 1'b0;
            itfRd.rdVld <= 1'b0;
        end else begin
            polRd.rdVld <= polRd.rdEn;
            itfRd.rdVld <= itfRd.rdEn && !polRd.rdEn;
        end
    end

    // Single read path shared by both clients
    assign polRd.rdDat = rdDatQ;
    assign itfRd.rdDat = rdDatQ;

endmodule

// File: hw/padInterface.sv
`timescale 1ns/1ps
`include "accel_params.svh"

module padInterface
    import accelPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  wordT    datIn,
    input  logic    datInVld,
    output logic    datInRdy,
    output wordT    datOut,
    output logic    datOutVld,
    output logic    datOutLast,
    input  logic    datOutRdy,
    output logic    datOE,
    input  logic    loadEn,
    output cntT     inCnt,
    input  logic    dumpStart,
    input  cntT     outCnt,
    output logic    dumpDone,
    output logic    wrEn,
    output glbAddrT wrAddr,
    output wordT    wrDat,
    glbRdIf.client  rd
);
    logic inFire;
    logic outFire;
    cntT  outIdx;
    cntT  nextIdx;

    assign datInRdy = loadEn && (inCnt < cntT'(`MAX_IN_WORDS));
    assign inFire   = datInVld && datInRdy;
    assign outFire  = datOutVld && datOutRdy;
    assign nextIdx  = outIdx + cntT'(1);

    // ====================
    // Load path
    // ====================
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            inCnt <= '0;
            wrEn  <= 1'b0;
        end else begin
            wrEn <= inFire;
            if (inFire) begin
                inCnt <= inCnt + cntT'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inFire) begin
            wrAddr <= glbAddrT'(inCnt);
            wrDat  <= datIn;
        end
        if (rd.rdVld) begin
            datOut <= rd.rdDat;
        end
    end

    // ====================
    // Result dump
    // ====================
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            datOE      <= 1'b0;
            datOutVld  <= 1'b0;
            datOutLast <= 1'b0;
            dumpDone   <= 1'b0;
            outIdx     <= '0;
            rd.rdEn    <= 1'b0;
            rd.rdAddr  <= '0;
        end else begin
            rd.rdEn  <= 1'b0;
            dumpDone <= 1'b0;
            if (dumpStart) begin
                datOE  <= 1'b1;
                outIdx <= '0;
                if (outCnt == '0) begin
                    dumpDone <= 1'b1;
                end else begin
                    rd.rdEn   <= 1'b1;
                    rd.rdAddr <= glbAddrT'(`OUT_BASE);
                end
            end
            if (rd.rdVld) begin
                datOutVld  <= 1'b1;
                datOutLast <= (nextIdx == outCnt);
            end else if (outFire) begin
                datOutVld  <= 1'b0;
                datOutLast <= 1'b0;
                // Next word fetched only once the host took this one
                if (datOutLast) begin
                    dumpDone <= 1'b1;
                end else begin
                    outIdx    <= nextIdx;
                    rd.rdEn   <= 1'b1;
                    rd.rdAddr <= glbAddrT'(`OUT_BASE + nextIdx);
                end
            end
        end
    end

endmodule

// File: hw/maxPoolEngine.sv
`timescale 1ns/1ps
`include "accel_params.svh"

module maxPoolEngine
    import accelPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  logic    polStart,
    input  cntT     outCnt,
    output logic    polDone,
    output logic    wrEn,
    output glbAddrT wrAddr,
    output wordT    wrDat,
    glbRdIf.client  rd
);
    localparam int GrpW = $clog2(`POOL_K);

    logic [GrpW-1:0] inGrp;
    cntT             grpIdx;
    wordT            acc;
    wordT            laneMax;
    glbAddrT         lastRdAddr;

    assign lastRdAddr = glbAddrT'(outCnt * `POOL_K - 1);
    assign wrAddr     = glbAddrT'(`OUT_BASE + grpIdx);
    assign wrDat      = acc;

    // ====================
    // Read issue, one word per cycle
    // ====================
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rd.rdEn   <= 1'b0;
            rd.rdAddr <= '0;
        end else if (polStart) begin
            rd.rdEn   <= (outCnt != '0);
            rd.rdAddr <= '0;
        end else if (rd.rdEn) begin
            if (rd.rdAddr == lastRdAddr) begin
                rd.rdEn <= 1'b0;
            end else begin
                rd.rdAddr <= rd.rdAddr + glbAddrT'(1);
            end
        end
    end

    // Lane-wise unsigned max, restarts on first word of a group
    always_comb begin
        actT curAct;
        actT newAct;
        laneMax = rd.rdDat;
        for (int l = 0; l < `NUM_LANE; l++) begin
            curAct = acc[l*`ACT_WIDTH +: `ACT_WIDTH];
            newAct = rd.rdDat[l*`ACT_WIDTH +: `ACT_WIDTH];
            if (inGrp != '0 && curAct > newAct) begin
                laneMax[l*`ACT_WIDTH +: `ACT_WIDTH] = curAct;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd.rdVld) begin
            acc <= laneMax;
        end
    end

    // ====================
    // Group tracking and write-back
    // ====================
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            inGrp   <= '0;
            grpIdx  <= '0;
            wrEn    <= 1'b0;
            polDone <= 1'b0;
        end else begin
            wrEn    <= 1'b0;
            polDone <= 1'b0;
            if (polStart) begin
                inGrp   <= '0;
                grpIdx  <= '0;
                polDone <= (outCnt == '0);
            end
            if (rd.rdVld) begin
                if (inGrp == GrpW'(`POOL_K - 1)) begin
                    inGrp <= '0;
                    wrEn  <= 1'b1;
                end else begin
                    inGrp <= inGrp + 1'b1;
                end
            end
            if (wrEn) begin
                grpIdx  <= grpIdx + cntT'(1);
                polDone <= (grpIdx == outCnt - cntT'(1));
            end
        end
    end

endmodule

// File: hw/ctrlUnit.sv
`timescale 1ns/1ps
`include "accel_params.svh"

module ctrlUnit
    import accelPkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic start,
    input  cntT  inCnt,
    output logic loadEn,
    output cntT  outCnt,
    output logic polStart,
    input  logic polDone,
    output logic dumpStart,
    input  logic dumpDone,
    output logic netFnh
);
    ctrlStateT state;

    assign loadEn = (state == ST_LOAD);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= ST_LOAD;
            outCnt    <= '0;
            polStart  <= 1'b0;
            dumpStart <= 1'b0;
            netFnh    <= 1'b0;
        end else begin
            polStart  <= 1'b0;
            dumpStart <= 1'b0;
            case (state)
                ST_LOAD: begin
                    if (start) begin
                        // Leftover words of a partial group are dropped
                        outCnt   <= cntT'(inCnt / `POOL_K);
                        polStart <= 1'b1;
                        state    <= ST_POOL;
                    end
                end
                ST_POOL: begin
                    if (polDone) begin
                        dumpStart <= 1'b1;
                        state     <= ST_DUMP;
                    end
                end
                ST_DUMP: begin
                    if (dumpDone) begin
                        netFnh <= 1'b1;
                        state  <= ST_DONE;
                    end
                end
                default: begin
                    // Held until the next reset
                    state <= ST_DONE;
                end
            endcase
        end
    end

endmodule

// File: hw/accelTop.sv
`timescale 1ns/1ps

module accelTop
    import accelPkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic startPulse,
    input  wordT datIn,
    input  logic datInVld,
    output logic datInRdy,
    output wordT datOut,
    output logic datOutVld,
    output logic datOutLast,
    input  logic datOutRdy,
    output logic datOE,
    output logic netFnh
);
    logic    start;
    logic    loadEn;
    cntT     inCnt;
    cntT     outCnt;
    logic    polStart;
    logic    polDone;
    logic    dumpStart;
    logic    dumpDone;

    // Buffer write ports
    logic    itfWrEn;
    glbAddrT itfWrAddr;
    wordT    itfWrDat;
    logic    polWrEn;
    glbAddrT polWrAddr;
    wordT    polWrDat;

    glbRdIf itfRd ();
    glbRdIf polRd ();

    startDebounce uDebounce (
        .clk   (clk),
        .rstN  (rstN),
        .btn   (startPulse),
        .start (start)
    );

    ctrlUnit uCtrl (
        .clk       (clk),
        .rstN      (rstN),
        .start     (start),
        .inCnt     (inCnt),
        .loadEn    (loadEn),
        .outCnt    (outCnt),
        .polStart  (polStart),
        .polDone   (polDone),
        .dumpStart (dumpStart),
        .dumpDone  (dumpDone),
        .netFnh    (netFnh)
    );

    padInterface uPad (
        .clk        (clk),
        .rstN       (rstN),
        .datIn      (datIn),
        .datInVld   (datInVld),
        .datInRdy   (datInRdy),
        .datOut     (datOut),
        .datOutVld  (datOutVld),
        .datOutLast (datOutLast),
        .datOutRdy  (datOutRdy),
        .datOE      (datOE),
        .loadEn     (loadEn),
        .inCnt      (inCnt),
        .dumpStart  (dumpStart),
        .outCnt     (outCnt),
        .dumpDone   (dumpDone),
        .wrEn       (itfWrEn),
        .wrAddr     (itfWrAddr),
        .wrDat      (itfWrDat),
        .rd         (itfRd.client)
    );

    maxPoolEngine uPool (
        .clk      (clk),
        .rstN     (rstN),
        .polStart (polStart),
        .outCnt   (outCnt),
        .polDone  (polDone),
        .wrEn     (polWrEn),
        .wrAddr   (polWrAddr),
        .wrDat    (polWrDat),
        .rd       (polRd.client)
    );

    globalBuffer uGlb (
        .clk       (clk),
        .rstN      (rstN),
        .itfWrEn   (itfWrEn),
        .itfWrAddr (itfWrAddr),
        .itfWrDat  (itfWrDat),
        .polWrEn   (polWrEn),
        .polWrAddr (polWrAddr),
        .polWrDat  (polWrDat),
        .itfRd     (itfRd.buffer),
        .polRd     (polRd.buffer)
    );

endmodule

// File: verification/accelTb.sv
`timescale 1ns/1ps
`include "accel_params.svh"

module accelTb
    import accelPkg::*;
();
    localparam int          ClkPeriod     = 8;
    localparam logic [31:0] LfsrSeed      = 32'h29a4;
    localparam int          TimeoutFactor = 4;
    localparam int          CollectLimit  = 400;
    localparam int          PressCycles   = `DEB_CYCLES + 4;
    localparam int          HoldCycles    = 4;

    // Rough length of each test in cycles
    localparam int LenReset      = 10;
    localparam int LenBasic      = 100;
    localparam int LenBackPress  = 120;
    localparam int LenIncomplete = 110;
    localparam int LenGlitch     = 200;
    localparam int LenFull       = 180;
    localparam int TestCycles    = LenReset + LenBasic + LenBackPress + LenIncomplete
                                 + LenGlitch + LenFull;

    logic clk;
    logic rstN;
    logic startPulse;
    wordT datIn;
    logic datInVld;
    logic datInRdy;
    wordT datOut;
    logic datOutVld;
    logic datOutLast;
    logic datOutRdy;
    logic datOE;
    logic netFnh;

    logic [31:0] lfsr = LfsrSeed;
    int          errCnt = 0;
    int          checkCnt = 0;
    wordT        sent[$];
    wordT        got[$];
    logic        gotLast[$];

    accelTop UUT (
        .clk        (clk),
        .rstN       (rstN),
        .startPulse (startPulse),
        .datIn      (datIn),
        .datInVld   (datInVld),
        .datInRdy   (datInRdy),
        .datOut     (datOut),
        .datOutVld  (datOutVld),
        .datOutLast (datOutLast),
        .datOutRdy  (datOutRdy),
        .datOE      (datOE),
        .netFnh     (netFnh)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // ====================
    // Helpers
    // ====================

    // Taps 32, 22, 2, 1
    function automatic logic lfsrBit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic wordT randomWord();
        wordT w;
        for (int b = 0; b < `PORT_WIDTH; b++) begin
            w[b] = lfsrBit();
        end
        return w;
    endfunction

    // Lane-wise unsigned maximum over one group of sent words
    function automatic wordT expectedMax(input int grp);
        wordT best;
        actT  lane;
        best = '0;
        for (int w = 0; w < `POOL_K; w++) begin
            for (int l = 0; l < `NUM_LANE; l++) begin
                lane = sent[grp * `POOL_K + w][l * `ACT_WIDTH +: `ACT_WIDTH];
                if (lane > best[l * `ACT_WIDTH +: `ACT_WIDTH]) begin
                    best[l * `ACT_WIDTH +: `ACT_WIDTH] = lane;
                end
            end
        end
        return best;
    endfunction

    task automatic checkEqual(input string name, input logic [31:0] val,
                              input logic [31:0] exp);
        checkCnt++;
        assert (val === exp) else begin
            errCnt++;
            $display("CHECK FAILED at %0t: %s = %0h, expected %0h", $time, name, val, exp);
        end
    endtask

    task automatic resetDut();
        @(posedge clk);
        rstN       <= 1'b0;
        startPulse <= 1'b0;
        datInVld   <= 1'b0;
        datOutRdy  <= 1'b0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
    endtask

    // Each word transfers on the edge after ready is seen
    task automatic loadRandomWords(input int n);
        wordT w;
        sent.delete();
        for (int i = 0; i < n; i++) begin
            w = randomWord();
            sent.push_back(w);
            @(posedge clk);
            datIn    <= w;
            datInVld <= 1'b1;
            @(negedge clk);
            while (!datInRdy) @(negedge clk);
        end
        @(posedge clk);
        datInVld <= 1'b0;
    endtask

    task automatic pressButton(input int holdCycles);
        @(posedge clk);
        startPulse <= 1'b1;
        repeat (holdCycles) @(posedge clk);
        startPulse <= 1'b0;
    endtask

    task automatic collectResults(input bit randomRdy);
        int   cycles;
        logic done;
        got.delete();
        gotLast.delete();
        cycles = 0;
        done = 1'b0;
        while (!done && cycles < CollectLimit) begin
            @(posedge clk);
            if (randomRdy) begin
                datOutRdy <= lfsrBit();
            end else begin
                datOutRdy <= 1'b1;
            end
            @(negedge clk);
            if (datOutVld && datOutRdy) begin
                got.push_back(datOut);
                gotLast.push_back(datOutLast);
            end
            done = netFnh;
            cycles++;
        end
        checkCnt++;
        assert (done) else begin
            errCnt++;
            $display("At %0t netFnh did not rise within %0d cycles", $time, CollectLimit);
        end
    endtask

    task automatic checkResults(input int nGroups);
        int n;
        checkEqual("result count", got.size(), nGroups);
        n = (got.size() < nGroups) ? got.size() : nGroups;
        for (int g = 0; g < n; g++) begin
            checkEqual($sformatf("datOut[%0d]", g), got[g], expectedMax(g));
            checkEqual($sformatf("datOutLast[%0d]", g), gotLast[g], g == nGroups - 1);
        end
        // Finish flag and output enable hold once the run is over
        repeat (HoldCycles) @(posedge clk);
        @(negedge clk);
        checkEqual("datOutVld", datOutVld, 1'b0);
        checkEqual("netFnh", netFnh, 1'b1);
        checkEqual("datOE", datOE, 1'b1);
    endtask

    task automatic runPooling(input int nWords, input bit randomRdy);
        loadRandomWords(nWords);
        pressButton(PressCycles);
        collectResults(randomRdy);
        checkResults(nWords / `POOL_K);
    endtask

    // ====================
    // Tests
    // ====================
    task automatic afterResetState();
        resetDut();
        @(negedge clk);
        checkEqual("datOE", datOE, 1'b0);
        checkEqual("datOutVld", datOutVld, 1'b0);
        checkEqual("datOutLast", datOutLast, 1'b0);
        checkEqual("netFnh", netFnh, 1'b0);
        checkEqual("datInRdy", datInRdy, 1'b1);
    endtask

    task automatic basicPooling();
        resetDut();
        runPooling(8, 1'b0);
    endtask

    task automatic backPressure();
        resetDut();
        runPooling(8, 1'b1);
    endtask

    // Two leftover words never reach a result
    task automatic incompleteGroup();
        resetDut();
        runPooling(10, 1'b0);
    endtask

    task automatic shortGlitch();
        resetDut();
        loadRandomWords(8);
        pressButton(`DEB_CYCLES / 2);
        repeat (4 * `DEB_CYCLES) @(posedge clk);
        @(negedge clk);
        checkEqual("netFnh", netFnh, 1'b0);
        checkEqual("datOE", datOE, 1'b0);
        checkEqual("datInRdy", datInRdy, 1'b1);
        pressButton(PressCycles);
        collectResults(1'b0);
        checkResults(2);
    endtask

    task automatic fullLoad();
        resetDut();
        loadRandomWords(`MAX_IN_WORDS);
        @(negedge clk);
        checkEqual("datInRdy", datInRdy, 1'b0);
        pressButton(PressCycles);
        collectResults(1'b0);
        checkResults(`MAX_IN_WORDS / `POOL_K);
    endtask

    // ====================
    // Main sequence and watchdog
    // ====================
    initial begin
        rstN       = 1'b0;
        startPulse = 1'b0;
        datIn      = '0;
        datInVld   = 1'b0;
        datOutRdy  = 1'b0;
        afterResetState();
        basicPooling();
        backPressure();
        incompleteGroup();
        shortGlitch();
        fullLoad();
        $display("Checks run: %0d, errors: %0d", checkCnt, errCnt);
        if (errCnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(TestCycles * TimeoutFactor * ClkPeriod);
        $display("Watchdog expired at %0t, the tests did not finish in time", $time);
        $display("Checks run: %0d, errors: %0d", checkCnt, errCnt + 1);
        $display("Errors found");
        $finish;
    end

endmodule

// File: flist.f
+incdir+hw
hw/accelPkg.sv
hw/glbRdIf.sv
hw/startDebounce.sv
hw/globalBuffer.sv
hw/padInterface.sv
hw/maxPoolEngine.sv
hw/ctrlUnit.sv
hw/accelTop.sv
verification/accelTb.sv

// File: run.sh
#!/bin/sh
# Build and run the accelerator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module accelTb \
    -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VaccelTb > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "No errors" sim.log; then
    exit 0
fi
exit 1
